// File: ps2_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// timing constants assume a 50 MHz system clock
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package ps2_pkg;

  // 100 us of high clock before the host may start a transfer
  localparam int quiet_cycles = 5000;
  // 80 us of clock held low to request a host-to-device transfer
  localparam int inhibit_cycles = 4000;

  localparam int quiet_width = $clog2(quiet_cycles + 1);
  localparam int inhibit_width = $clog2(inhibit_cycles + 1);

  // line filter integrator and its hysteresis marks
  localparam int filt_width = 4;
  localparam logic [filt_width-1:0] filt_low_mark = 4'd4;
  localparam logic [filt_width-1:0] filt_high_mark = 4'd11;

  // register map, one address bit
  typedef enum logic {
    reg_data   = 1'b0,
    reg_status = 1'b1
  } reg_addr_t;

  // status register bit positions
  localparam int st_rx_valid = 0;
  localparam int st_rx_error = 1;
  localparam int st_rx_overrun = 2;
  localparam int st_tx_ready = 3;

  typedef enum logic [2:0] {
    st_idle,
    st_rx_wait_rise,
    st_rx_wait_fall,
    st_tx_inhibit,
    st_tx_wait_rise,
    st_tx_wait_fall,
    st_tx_wait_end
  } host_state_t;

endpackage

`default_nettype wire

// File: ps2_line_filter.sv
// ~~~~~~~~~~~~~~~~~~~~
// output lags a clean edge by 13 clocks
// pulses under about 7 clocks are ignored
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ps2_line_filter import ps2_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  logic line,
  output logic level
);

  logic sync_1;
  logic sync_2;
  logic [filt_width-1:0] integ;
  logic [filt_width-1:0] integ_nxt;

  // two-flop synchronizer for the asynchronous line
  always_ff @(posedge clk) begin
    sync_1 <= line;
    sync_2 <= sync_1;
  end

  // up/down count, saturating at both ends
  always_comb begin
    integ_nxt = integ;
    if (sync_2 && integ != '1) begin
      integ_nxt = integ + 1'b1;
    end else if (!sync_2 && integ != '0) begin
      integ_nxt = integ - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      integ <= '1;
    end else begin
      integ <= integ_nxt;
    end
  end

  // hysteresis: switch only when a mark is reached
  always_ff @(posedge clk) begin
    if (rst) begin
      level <= 1'b1;
    end else if (integ_nxt == filt_low_mark) begin
      level <= 1'b0;
    end else if (integ_nxt == filt_high_mark) begin
      level <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: ps2_host.sv
// ~~~~~~~~~~~~~~~~~~~~
// expects filtered clock and data levels
// no timeout if the device stops clocking mid-frame
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ps2_host import ps2_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       clk_lvl,
  input  logic       data_lvl,
  input  logic [7:0] tx_byte,
  input  logic       tx_request,
  output logic       tx_taken,
  output logic       tx_ready,
  output logic [7:0] rx_byte,
  output logic       rx_error,
  output logic       rx_done,
  output logic       ps2_clk_pull,
  output logic       ps2_data_pull
);

  host_state_t state;
  host_state_t state_nxt;

  logic [10:0] sr;
  logic [3:0] bc;
  logic sr_load;
  logic sr_shift;
  logic bc_clear;

  logic [quiet_width-1:0] quiet_cnt;
  logic [inhibit_width-1:0] inhibit_cnt;
  logic clk_quiet;
  logic inhibit_done;

  logic framing_error;
  logic parity_error;

  // frame shift register: stop, parity, data, start from msb down
  always_ff @(posedge clk) begin
    if (sr_load) begin
      sr <= {1'b1, ~^tx_byte, tx_byte, 1'b0};
    end else if (sr_shift) begin
      sr <= {data_lvl, sr[10:1]};
    end
  end

  always_ff @(posedge clk) begin
    if (rst || bc_clear) begin
      bc <= '0;
    end else if (sr_shift) begin
      bc <= bc + 4'd1;
    end
  end

  // counts down while the clock line stays high
  always_ff @(posedge clk) begin
    if (rst || !clk_lvl) begin
      quiet_cnt <= quiet_width'(quiet_cycles);
    end else if (!clk_quiet) begin
      quiet_cnt <= quiet_cnt - 1'b1;
    end
  end

  assign clk_quiet = (quiet_cnt == '0);

  // times the clock inhibit from the moment the host pulls it
  always_ff @(posedge clk) begin
    if (rst || state != st_tx_inhibit) begin
      inhibit_cnt <= inhibit_width'(inhibit_cycles - 1);
    end else if (!inhibit_done) begin
      inhibit_cnt <= inhibit_cnt - 1'b1;
    end
  end

  assign inhibit_done = (inhibit_cnt == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  assign tx_ready = (state == st_idle) && clk_quiet;

  always_comb begin
    state_nxt = state;
    sr_load = 1'b0;
    sr_shift = 1'b0;
    bc_clear = 1'b0;
    tx_taken = 1'b0;
    rx_done = 1'b0;
    ps2_clk_pull = 1'b0;
    ps2_data_pull = 1'b0;
    case (state)
      st_idle: begin
        if (!clk_lvl) begin
          // device opened a frame, start bit is on the line now
          sr_shift = 1'b1;
          state_nxt = st_rx_wait_rise;
        end else if (tx_ready && tx_request) begin
          sr_load = 1'b1;
          bc_clear = 1'b1;
          tx_taken = 1'b1;
          state_nxt = st_tx_inhibit;
        end else begin
          bc_clear = 1'b1;
        end
      end
      st_rx_wait_rise: begin
        if (clk_lvl) begin
          // all 11 bits are in after the last rising edge
          if (bc == 4'd11) begin
            rx_done = 1'b1;
            state_nxt = st_idle;
          end else begin
            state_nxt = st_rx_wait_fall;
          end
        end
      end
      st_rx_wait_fall: begin
        if (!clk_lvl) begin
          sr_shift = 1'b1;
          state_nxt = st_rx_wait_rise;
        end
      end
      st_tx_inhibit: begin
        // hold clock low, start bit already on data
        ps2_clk_pull = 1'b1;
        ps2_data_pull = ~sr[0];
        if (inhibit_done) begin
          state_nxt = st_tx_wait_rise;
        end
      end
      st_tx_wait_rise: begin
        ps2_data_pull = ~sr[0];
        if (clk_lvl) begin
          state_nxt = st_tx_wait_fall;
        end
      end
      st_tx_wait_fall: begin
        ps2_data_pull = ~sr[0];
        if (!clk_lvl) begin
          // after the stop bit, release data for the device ack
          if (bc == 4'd10) begin
            state_nxt = st_tx_wait_end;
          end else begin
            sr_shift = 1'b1;
            state_nxt = st_tx_wait_rise;
          end
        end
      end
      st_tx_wait_end: begin
        if (clk_lvl) begin
          state_nxt = st_idle;
        end
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  // received frame, valid while rx_done pulses
  assign rx_byte = sr[8:1];
  assign framing_error = sr[0] | ~sr[10];
  // odd parity over data plus parity bit
  assign parity_error = ~^sr[9:1];
  assign rx_error = framing_error | parity_error;

endmodule

`default_nettype wire

// File: ps2_wb_regs.sv
// ~~~~~~~~~~~~~~~~~~~~
// one-byte receive latch, no FIFO
// writes while a byte is pending are dropped
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ps2_wb_regs import ps2_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  logic       wb_we,
  input  logic       wb_adr,
  input  logic [7:0] wb_dat_w,
  output logic [7:0] wb_dat_r,
  output logic       wb_ack,
  input  logic [7:0] rx_byte,
  input  logic       rx_error,
  input  logic       rx_done,
  input  logic       tx_ready,
  input  logic       tx_taken,
  output logic [7:0] tx_byte,
  output logic       tx_request
);

  reg_addr_t addr;
  logic req;
  logic rd_data;
  logic wr_data;

  logic [7:0] rx_data;
  logic rx_err;
  logic rx_valid;
  logic rx_overrun;
  logic [7:0] status;

  assign addr = reg_addr_t'(wb_adr);
  // first cycle of a request only, ack follows one cycle later
  assign req = wb_cyc && wb_stb && !wb_ack;
  assign rd_data = req && !wb_we && (addr == reg_data);
  assign wr_data = req && wb_we && (addr == reg_data);

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_ack <= 1'b0;
    end else begin
      wb_ack <= req;
    end
  end

  always_comb begin
    status = '0;
    status[st_rx_valid] = rx_valid;
    status[st_rx_error] = rx_err;
    status[st_rx_overrun] = rx_overrun;
    // not ready while a queued byte waits for the engine
    status[st_tx_ready] = tx_ready && !tx_request;
  end

  always_ff @(posedge clk) begin
    if (req && !wb_we) begin
      case (addr)
        reg_data:   wb_dat_r <= rx_data;
        reg_status: wb_dat_r <= status;
        default:    wb_dat_r <= '0;
      endcase
    end
  end

  // receive latch, a new byte overwrites an unread one
  always_ff @(posedge clk) begin
    if (rx_done) begin
      rx_data <= rx_byte;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rx_valid <= 1'b0;
      rx_overrun <= 1'b0;
      rx_err <= 1'b0;
    end else if (rx_done) begin
      rx_valid <= 1'b1;
      rx_err <= rx_error;
      // a read in the same cycle takes the old byte, so no overrun
      rx_overrun <= (rx_overrun | rx_valid) & ~rd_data;
    end else if (rd_data) begin
      rx_valid <= 1'b0;
      rx_overrun <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_data && !tx_request) begin
      tx_byte <= wb_dat_w;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      tx_request <= 1'b0;
    end else if (tx_taken) begin
      tx_request <= 1'b0;
    end else if (wr_data) begin
      tx_request <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: ps2_wb_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// PS/2 lines split into sensed level and pull-low request
// wired-AND of the two is formed outside
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ps2_wb_top (
  input  logic       clk,
  input  logic       rst,
  input  logic       wb_cyc,
  input  logic       wb_stb,
  input  logic       wb_we,
  input  logic       wb_adr,
  input  logic [7:0] wb_dat_w,
  output logic [7:0] wb_dat_r,
  output logic       wb_ack,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  output logic       ps2_clk_pull,
  output logic       ps2_data_pull
);

  logic clk_lvl;
  logic data_lvl;
  logic [7:0] tx_byte;
  logic tx_request;
  logic tx_taken;
  logic tx_ready;
  logic [7:0] rx_byte;
  logic rx_error;
  logic rx_done;

  ps2_line_filter u_clk_filter (
    .clk   (clk),
    .rst   (rst),
    .line  (ps2_clk),
    .level (clk_lvl)
  );

  ps2_line_filter u_data_filter (
    .clk   (clk),
    .rst   (rst),
    .line  (ps2_data),
    .level (data_lvl)
  );

  ps2_host u_host (
    .clk           (clk),
    .rst           (rst),
    .clk_lvl       (clk_lvl),
    .data_lvl      (data_lvl),
    .tx_byte       (tx_byte),
    .tx_request    (tx_request),
    .tx_taken      (tx_taken),
    .tx_ready      (tx_ready),
    .rx_byte       (rx_byte),
    .rx_error      (rx_error),
    .rx_done       (rx_done),
    .ps2_clk_pull  (ps2_clk_pull),
    .ps2_data_pull (ps2_data_pull)
  );

  ps2_wb_regs u_regs (
    .clk        (clk),
    .rst        (rst),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .rx_byte    (rx_byte),
    .rx_error   (rx_error),
    .rx_done    (rx_done),
    .tx_ready   (tx_ready),
    .tx_taken   (tx_taken),
    .tx_byte    (tx_byte),
    .tx_request (tx_request)
  );

endmodule

`default_nettype wire

// File: ps2_device_model.sv
// ~~~~~~~~~~~~~~~~~~~~
// behavioral PS/2 device for simulation only
// 10 us half periods, no acknowledge bit after a host frame
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module ps2_device_model (
  input  logic ps2_clk,
  input  logic ps2_data,
  output logic clk_pull,
  output logic data_pull
);

  // half of one device clock period in ns
  localparam int half_ns = 10000;

  initial begin
    clk_pull = 1'b0;
    data_pull = 1'b0;
  end

  // err_kind 0 sends a clean frame, 1 flips parity, 2 clears the stop bit
  task automatic send_frame(input logic [7:0] value, input int err_kind);
    logic [10:0] frame;
    frame = {1'b1, ~^value, value, 1'b0};
    if (err_kind == 1) begin
      frame[9] = ~frame[9];
    end
    if (err_kind == 2) begin
      frame[10] = 1'b0;
    end
    // data changes in the middle of the high phase
    for (int i = 0; i < 11; i++) begin
      data_pull = ~frame[i];
      #(half_ns / 2);
      clk_pull = 1'b1;
      #(half_ns);
      clk_pull = 1'b0;
      #(half_ns / 2);
    end
    data_pull = 1'b0;
    #(half_ns / 2);
  endtask

  // bits[0] is the start bit, bits[8:1] the data, bits[9] the parity
  task automatic capture_frame(output logic [9:0] bits);
    bits = '0;
    // host inhibits the clock, then releases it with data held low
    wait (ps2_clk === 1'b0);
    wait (ps2_clk === 1'b1 && ps2_data === 1'b0);
    for (int i = 0; i < 11; i++) begin
      #(half_ns);
      // sample late in the high phase, host shifts after each fall
      if (i < 10) begin
        bits[i] = ps2_data;
      end
      clk_pull = 1'b1;
      #(half_ns);
      clk_pull = 1'b0;
    end
  endtask

endmodule

`default_nettype wire

// File: tb_ps2_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// reads ps2_golden.txt from the project root
// 4 ns clock, so quiet and inhibit times are shorter than on hardware
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_ps2_top import ps2_pkg::*; ();

  localparam int clk_period = 4;
  localparam int max_steps = 64;
  // one full device clock period in ns
  localparam longint ps2_period = 20000;

  logic clk;
  logic rst;
  logic wb_cyc;
  logic wb_stb;
  logic wb_we;
  logic wb_adr;
  logic [7:0] wb_dat_w;
  logic [7:0] wb_dat_r;
  logic wb_ack;
  logic host_clk_pull;
  logic host_data_pull;
  logic dev_clk_pull;
  logic dev_data_pull;
  logic ps2_clk_line;
  logic ps2_data_line;

  // op 0 is rx, 1 is tx, 2 is rx2; err 0 none, 1 parity, 2 stop
  int op_list [max_steps];
  logic [7:0] byte_list [max_steps];
  int err_list [max_steps];
  logic [7:0] status_list [max_steps];
  int step_count;
  int pass_count;
  int fail_count;
  int step_errors;
  logic loaded;

  // open-collector lines, either side may pull low
  assign ps2_clk_line = ~(host_clk_pull | dev_clk_pull);
  assign ps2_data_line = ~(host_data_pull | dev_data_pull);

  ps2_wb_top u_dut (
    .clk           (clk),
    .rst           (rst),
    .wb_cyc        (wb_cyc),
    .wb_stb        (wb_stb),
    .wb_we         (wb_we),
    .wb_adr        (wb_adr),
    .wb_dat_w      (wb_dat_w),
    .wb_dat_r      (wb_dat_r),
    .wb_ack        (wb_ack),
    .ps2_clk       (ps2_clk_line),
    .ps2_data      (ps2_data_line),
    .ps2_clk_pull  (host_clk_pull),
    .ps2_data_pull (host_data_pull)
  );

  ps2_device_model u_dev (
    .ps2_clk   (ps2_clk_line),
    .ps2_data  (ps2_data_line),
    .clk_pull  (dev_clk_pull),
    .data_pull (dev_data_pull)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(clk_period / 2) clk = ~clk;
    end
  end

  initial begin
    longint step_ns;
    longint limit_ns;
    wait (loaded);
    // longest step is inhibit, quiet and 11 device clocks, doubled for margin
    step_ns = longint'(inhibit_cycles + quiet_cycles) * clk_period + 11 * ps2_period;
    limit_ns = 2 * longint'(step_count + 1) * step_ns;
    #(limit_ns);
    $display("timeout: the run did not finish within %0d ns", limit_ns);
    $display("CHECKS FAILED");
    $finish;
  end

  // parity bit that makes the ones in data plus parity odd
  function automatic logic odd_parity(input logic [7:0] value);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++) begin
      if (value[i]) begin
        ones++;
      end
    end
    return (ones % 2 == 0);
  endfunction

  // start of one, stop of zero, or even ones over data and parity
  function automatic logic frame_error(input logic [7:0] value, input int err_kind);
    logic [10:0] frame;
    int ones;
    frame = {1'b1, odd_parity(value), value, 1'b0};
    if (err_kind == 1) begin
      frame[9] = ~frame[9];
    end
    if (err_kind == 2) begin
      frame[10] = 1'b0;
    end
    ones = 0;
    for (int i = 1; i < 10; i++) begin
      if (frame[i]) begin
        ones++;
      end
    end
    return frame[0] || !frame[10] || (ones % 2 == 0);
  endfunction

  task automatic expect_hex(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%02h expected 0x%02h", name, got, exp);
      step_errors++;
    end
  endtask

  task automatic end_step(input int index, input string what);
    if (step_errors == 0) begin
      pass_count++;
      $display("step %0d %s: ok", index, what);
    end else begin
      fail_count++;
      $display("step %0d %s: %0d mismatches", index, what, step_errors);
    end
    step_errors = 0;
  endtask

  task automatic load_golden();
    int fd;
    int ch;
    logic [63:0] op_tok;
    logic [63:0] err_tok;
    logic [7:0] value;
    logic [7:0] status;
    fd = $fopen("ps2_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open ps2_golden.txt");
      fail_count++;
      return;
    end
    while ($fscanf(fd, "%s", op_tok) == 1) begin
      if (op_tok == "#") begin
        ch = $fgetc(fd);
        while (ch != 10 && ch != -1) begin
          ch = $fgetc(fd);
        end
      end else if ($fscanf(fd, "%h %s %h", value, err_tok, status) == 3
                   && step_count < max_steps) begin
        op_list[step_count] = (op_tok == "tx") ? 1 : (op_tok == "rx2") ? 2 : 0;
        err_list[step_count] = (err_tok == "parity") ? 1 : (err_tok == "stop") ? 2 : 0;
        byte_list[step_count] = value;
        status_list[step_count] = status;
        step_count++;
      end
    end
    $fclose(fd);
  endtask

  // one classic cycle, inputs change 1 ns after the clock edge
  task automatic wb_access(input logic we, input logic adr, input logic [7:0] wdata,
                           output logic [7:0] rdata);
    int waited;
    waited = 0;
    @(posedge clk);
    #1;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = we;
    wb_adr = adr;
    wb_dat_w = wdata;
    do begin
      @(posedge clk);
      #1;
      waited++;
    end while (!wb_ack && waited < 8);
    if (!wb_ack) begin
      $display("bus error: no ack within 8 cycles");
      step_errors++;
    end
    rdata = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
  endtask

  task automatic poll_status(input int bit_pos, output logic [7:0] status);
    do begin
      wb_access(1'b0, reg_status, 8'h00, status);
    end while (!status[bit_pos]);
  endtask

  task automatic run_rx(input int index);
    logic [7:0] value;
    logic [7:0] status;
    logic [7:0] data;
    logic exp_err;
    value = byte_list[index];
    exp_err = frame_error(value, err_list[index]);
    // rx2 sends a clean first frame that must be overwritten
    if (op_list[index] == 2) begin
      u_dev.send_frame(~value, 0);
    end
    u_dev.send_frame(value, err_list[index]);
    poll_status(st_rx_valid, status);
    expect_hex("status", status & 8'h07, status_list[index] & 8'h07);
    expect_hex("status rx_error", {7'b0, status[st_rx_error]}, {7'b0, exp_err});
    wb_access(1'b0, reg_data, 8'h00, data);
    expect_hex("wb_dat_r", data, value);
    wb_access(1'b0, reg_status, 8'h00, status);
    expect_hex("status rx_valid", {7'b0, status[st_rx_valid]}, 8'h00);
    expect_hex("status rx_overrun", {7'b0, status[st_rx_overrun]}, 8'h00);
  endtask

  task automatic run_tx(input int index);
    logic [7:0] value;
    logic [7:0] status;
    logic [7:0] unused;
    logic [9:0] bits;
    value = byte_list[index];
    poll_status(st_tx_ready, status);
    wb_access(1'b1, reg_data, value, unused);
    u_dev.capture_frame(bits);
    expect_hex("ps2_data start", {7'b0, bits[0]}, 8'h00);
    expect_hex("ps2_data byte", bits[8:1], value);
    expect_hex("ps2_data parity", {7'b0, bits[9]}, {7'b0, odd_parity(value)});
    poll_status(st_tx_ready, status);
    expect_hex("status", status, status_list[index]);
    expect_hex("ps2_clk_pull", {7'b0, host_clk_pull}, 8'h00);
    expect_hex("ps2_data_pull", {7'b0, host_data_pull}, 8'h00);
  endtask

  initial begin
    logic [7:0] status;
    rst = 1'b1;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = 1'b0;
    wb_dat_w = 8'h00;
    step_count = 0;
    pass_count = 0;
    fail_count = 0;
    step_errors = 0;
    loaded = 1'b0;
    load_golden();
    loaded = 1'b1;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;

    expect_hex("ps2_clk_pull", {7'b0, host_clk_pull}, 8'h00);
    expect_hex("ps2_data_pull", {7'b0, host_data_pull}, 8'h00);
    wb_access(1'b0, reg_status, 8'h00, status);
    expect_hex("status", status & 8'h07, 8'h00);
    // tx_ready comes up once the clock line has been quiet long enough
    poll_status(st_tx_ready, status);
    end_step(0, "reset");

    for (int i = 0; i < step_count; i++) begin
      if (op_list[i] == 1) begin
        run_tx(i);
        end_step(i + 1, $sformatf("tx %02h", byte_list[i]));
      end else if (op_list[i] == 2) begin
        run_rx(i);
        end_step(i + 1, $sformatf("rx2 %02h", byte_list[i]));
      end else begin
        run_rx(i);
        end_step(i + 1, $sformatf("rx %02h", byte_list[i]));
      end
    end

    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0 && step_count > 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: ps2_golden.txt
# columns: op (rx, tx, rx2), byte in hex, error (none, parity, stop), status in hex
# rx steps compare status bits 2:0 before the data read, tx steps all bits after the frame
rx  3c  none    01
rx  a5  none    01
rx  00  none    01
rx  ff  none    01
tx  ed  none    08
tx  f4  none    08
rx  5a  parity  03
rx  81  stop    03
tx  20  none    0a
rx  7e  none    01
rx2 12  none    05
tx  ff  none    08
rx2 c3  parity  07
rx  66  none    01
tx  01  none    08

// File: build.f
ps2_pkg.sv
ps2_line_filter.sv
ps2_host.sv
ps2_wb_regs.sv
ps2_wb_top.sv
ps2_device_model.sv
tb_ps2_top.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_ps2_top -f build.f -o tb_ps2_sim \
  && ./obj_dir/tb_ps2_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "no result in log"; exit 1; }
echo "simulation passed"
exit 0
